//--- rtl/reg_access_pkg.sv
/*
 * Register access stage definitions
 * Operand, size and stack encodings plus the micro-op structs exchanged
 * with decode and address generation
 */
package reg_access_pkg;

    localparam int GPR_COUNT = 8;
    localparam int SEG_COUNT = 6;
    localparam logic [2:0] ESP_NUM = 3'd4;

    // Up to three writes in flight per register
    localparam int SCORE_W = 2;

    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2
    } reg_size_e;

    // OPK_MODRM_RM keeps the value 4 used by the decoder
    typedef enum logic [2:0] {
        OPK_NONE     = 3'd0,
        OPK_REG      = 3'd1,
        OPK_IMM      = 3'd2,
        OPK_MEM      = 3'd3,
        OPK_MODRM_RM = 3'd4
    } opnd_kind_e;

    typedef enum logic [1:0] {
        STK_NONE = 2'd0,
        STK_PUSH = 2'd1,
        STK_POP  = 2'd2
    } stack_op_e;

    typedef enum logic [2:0] {
        ES = 3'd0,
        CS = 3'd1,
        SS = 3'd2,
        DS = 3'd3,
        FS = 3'd4,
        GS = 3'd5
    } seg_e;

    // Decoded micro-op as delivered by decode
    typedef struct packed {
        reg_size_e   size;
        opnd_kind_e  op0_kind;
        opnd_kind_e  op1_kind;
        logic [2:0]  op0_reg;
        logic [2:0]  op1_reg;
        logic [2:0]  dest_reg;
        logic        dest_valid;
        logic [7:0]  modrm;
        logic [31:0] imm;
        logic [31:0] disp;
        logic [3:0]  alu_op;
        stack_op_e   stack_op;
        seg_e        seg_override;
        logic        seg_override_valid;
        logic [31:0] pc;
        logic [15:0] opcode;
    } dec_uop_t;

    // Micro-op with resolved registers and their values
    typedef struct packed {
        dec_uop_t    uop;
        logic [31:0] op0_value;
        logic [31:0] op1_value;
        logic [15:0] seg_value;
        logic [31:0] stack_address;
    } ra_uop_t;

endpackage

//--- rtl/gpr_file.sv
/*
 * General purpose register file
 * Eight 32-bit registers, size-masked writeback, ESP commit port and
 * two read ports that see same-cycle writes
 */
`timescale 1ns/1ns

module gpr_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wb_reg_en,
    input  logic [2:0]                wb_reg_number,
    input  reg_access_pkg::reg_size_e wb_reg_size,
    input  logic [31:0]               wb_reg_data,
    input  logic                      esp_commit_en,
    input  logic [31:0]               esp_commit_value,
    input  logic [2:0]                rd0_num,
    input  logic [2:0]                rd1_num,
    output logic [31:0]               rd0_value,
    output logic [31:0]               rd1_value,
    output logic [31:0]               esp_value
);
    import reg_access_pkg::*;

    logic [31:0] gpr_q [GPR_COUNT];
    logic [31:0] gpr_d [GPR_COUNT];

    // Replace only the low bits covered by the write size
    function automatic logic [31:0] merge_write(
        input logic [31:0] old_value,
        input logic [31:0] data,
        input reg_size_e   size
    );
        logic [31:0] result;
        case (size)
            SZ_BYTE: result = {old_value[31:8], data[7:0]};
            SZ_WORD: result = {old_value[31:16], data[15:0]};
            default: result = data;
        endcase
        return result;
    endfunction

    always_comb begin
        gpr_d = gpr_q;
        if (wb_reg_en) begin
            gpr_d[wb_reg_number] = merge_write(gpr_q[wb_reg_number], wb_reg_data, wb_reg_size);
        end
        // Stack commit wins over a register write to ESP
        if (esp_commit_en) begin
            gpr_d[ESP_NUM] = esp_commit_value;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < GPR_COUNT; i++) begin
                gpr_q[i] <= '0;
            end
        end else begin
            gpr_q <= gpr_d;
        end
    end

    // Reads bypass the writes of this cycle
    assign rd0_value = gpr_d[rd0_num];
    assign rd1_value = gpr_d[rd1_num];

    // Stored ESP without bypass feeds the commit adder
    assign esp_value = gpr_q[ESP_NUM];

endmodule

//--- rtl/seg_file.sv
/*
 * Segment register file
 * Six 16-bit segment registers with writeback and direct CS write
 */
`timescale 1ns/1ns

module seg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_seg_en,
    input  reg_access_pkg::seg_e wb_seg_number,
    input  logic [15:0]          wb_seg_data,
    input  logic                 write_cs_enable,
    input  logic [15:0]          write_cs,
    input  reg_access_pkg::seg_e rd_seg,
    output logic [15:0]          seg_value,
    output logic [15:0]          ss_value
);
    import reg_access_pkg::*;

    logic [15:0] seg_q [SEG_COUNT];
    logic [15:0] seg_d [SEG_COUNT];

    always_comb begin
        seg_d = seg_q;
        if (wb_seg_en && (int'(wb_seg_number) < SEG_COUNT)) begin
            seg_d[wb_seg_number] = wb_seg_data;
        end
        // Direct CS write has the last word
        if (write_cs_enable) begin
            seg_d[CS] = write_cs;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SEG_COUNT; i++) begin
                seg_q[i] <= '0;
            end
        end else begin
            seg_q <= seg_d;
        end
    end

    // Unused encodings read as zero
    assign seg_value = (int'(rd_seg) < SEG_COUNT) ? seg_d[rd_seg] : 16'd0;
    assign ss_value  = seg_d[SS];

endmodule

//--- rtl/reg_scoreboard.sv
/*
 * Register scoreboard
 * Counts writes still in flight per register and stalls a micro-op
 * that reads one of them or needs ESP for a stack access
 */
`timescale 1ns/1ns

module reg_scoreboard (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     accept,
    input  reg_access_pkg::dec_uop_t uop,
    input  logic [2:0]               src0_num,
    input  logic [2:0]               src1_num,
    input  logic                     wb_reg_en,
    input  logic [2:0]               wb_reg_number,
    output logic                     stall
);
    import reg_access_pkg::*;

    logic [SCORE_W-1:0] pending_q [GPR_COUNT];
    logic [GPR_COUNT-1:0] inc;
    logic [GPR_COUNT-1:0] dec;
    logic src0_busy;
    logic src1_busy;
    logic stack_busy;

    function automatic logic is_reg_kind(input opnd_kind_e kind);
        return (kind == OPK_REG) || (kind == OPK_MODRM_RM);
    endfunction

    always_comb begin
        for (int i = 0; i < GPR_COUNT; i++) begin
            inc[i] = accept && uop.dest_valid && (uop.dest_reg == 3'(i));
            dec[i] = wb_reg_en && (wb_reg_number == 3'(i));
        end
    end

    // Accept and writeback of one register in one cycle cancel out
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < GPR_COUNT; i++) begin
                pending_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < GPR_COUNT; i++) begin
                pending_q[i] <= pending_q[i] + SCORE_W'(inc[i]) - SCORE_W'(dec[i]);
            end
        end
    end

    assign src0_busy  = is_reg_kind(uop.op0_kind) && (pending_q[src0_num] != '0);
    assign src1_busy  = is_reg_kind(uop.op1_kind) && (pending_q[src1_num] != '0);

    // Stack ops need a settled ESP
    assign stack_busy = (uop.stack_op != STK_NONE) && (pending_q[ESP_NUM] != '0);

    assign stall = src0_busy | src1_busy | stack_busy;

endmodule

//--- rtl/stack_tracker.sv
/*
 * Stack tracker
 * Speculative ESP for pushes and pops, stack linear address, and the
 * committed ESP update for the register file
 */
`timescale 1ns/1ns

module stack_tracker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      accept,
    input  reg_access_pkg::stack_op_e stack_op,
    input  reg_access_pkg::reg_size_e size,
    input  logic [15:0]               ss_value,
    input  logic                      wb_reg_en,
    input  logic [2:0]                wb_reg_number,
    input  logic                      wb_stack,
    input  logic [31:0]               wb_reg_data,
    input  logic [31:0]               committed_esp,
    input  logic                      wb_stack_en,
    input  reg_access_pkg::stack_op_e wb_stack_op,
    input  reg_access_pkg::reg_size_e wb_stack_size,
    output logic [31:0]               stack_address,
    output logic [31:0]               esp_commit_value
);
    import reg_access_pkg::*;

    logic [31:0] local_esp;
    logic [31:0] stack_base;
    logic [31:0] push_esp;
    logic [31:0] pop_esp;
    logic        esp_reload;

    // Word ops move the pointer by 2, everything else by 4
    function automatic logic [31:0] stack_step(input reg_size_e sz);
        return (sz == SZ_WORD) ? 32'd2 : 32'd4;
    endfunction

    assign push_esp   = local_esp - stack_step(size);
    assign pop_esp    = local_esp + stack_step(size);
    assign stack_base = {12'd0, ss_value, 4'd0};

    always_comb begin
        case (stack_op)
            STK_PUSH: stack_address = stack_base + push_esp;
            STK_POP:  stack_address = stack_base + local_esp;
            default:  stack_address = 32'd0;
        endcase
    end

    // Non-stack write to ESP from writeback
    assign esp_reload = wb_reg_en && (wb_reg_number == ESP_NUM) && !wb_stack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            local_esp <= '0;
        end else if (flush) begin
            local_esp <= committed_esp;
        end else if (esp_reload) begin
            local_esp <= wb_reg_data;
        end else if (accept && (stack_op == STK_PUSH)) begin
            local_esp <= push_esp;
        end else if (accept && (stack_op == STK_POP)) begin
            local_esp <= pop_esp;
        end
    end

    // Only meaningful while wb_stack_en is high
    always_comb begin
        esp_commit_value = committed_esp;
        if (wb_stack_en && (wb_stack_op == STK_PUSH)) begin
            esp_commit_value = committed_esp - stack_step(wb_stack_size);
        end else if (wb_stack_en && (wb_stack_op == STK_POP)) begin
            esp_commit_value = committed_esp + stack_step(wb_stack_size);
        end
    end

endmodule

//--- rtl/reg_access_top.sv
/*
 * Register access stage
 * Resolves operand registers, reads the register files, forms stack
 * addresses and registers the micro-op under valid/ready
 */
`timescale 1ns/1ns

module reg_access_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic [15:0]               write_cs,
    input  logic                      write_cs_enable,
    input  logic                      d_valid,
    output logic                      d_ready,
    input  reg_access_pkg::dec_uop_t  d_uop,
    output logic                      r_valid,
    input  logic                      r_ready,
    output reg_access_pkg::ra_uop_t   r_uop,
    input  logic                      wb_reg_en,
    input  logic [2:0]                wb_reg_number,
    input  reg_access_pkg::reg_size_e wb_reg_size,
    input  logic [31:0]               wb_reg_data,
    input  logic                      wb_stack,
    input  logic                      wb_seg_en,
    input  reg_access_pkg::seg_e      wb_seg_number,
    input  logic [15:0]               wb_seg_data,
    input  logic                      wb_stack_en,
    input  reg_access_pkg::stack_op_e wb_stack_op,
    input  reg_access_pkg::reg_size_e wb_stack_size
);
    import reg_access_pkg::*;

    logic [2:0]  src0_num;
    logic [2:0]  src1_num;
    seg_e        seg_sel;
    logic        accept;
    logic        stall;
    logic [31:0] op0_value;
    logic [31:0] op1_value;
    logic [15:0] seg_value;
    logic [15:0] ss_value;
    logic [31:0] committed_esp;
    logic [31:0] esp_commit_value;
    logic [31:0] stack_address;
    ra_uop_t     next_uop;

    // modrm r/m field for OPK_MODRM_RM, decoder reg field otherwise
    assign src0_num = (d_uop.op0_kind == OPK_MODRM_RM) ? d_uop.modrm[2:0] : d_uop.op0_reg;
    assign src1_num = (d_uop.op1_kind == OPK_MODRM_RM) ? d_uop.modrm[2:0] : d_uop.op1_reg;

    assign seg_sel = d_uop.seg_override_valid ? d_uop.seg_override : DS;

    // Output slot free or draining, no hazard, no flush
    assign d_ready = (!r_valid || r_ready) && !stall && !flush;
    assign accept  = d_valid && d_ready;

    gpr_file u_gpr_file (
        .clk              (clk),
        .rst_n            (rst_n),
        .wb_reg_en        (wb_reg_en),
        .wb_reg_number    (wb_reg_number),
        .wb_reg_size      (wb_reg_size),
        .wb_reg_data      (wb_reg_data),
        .esp_commit_en    (wb_stack_en),
        .esp_commit_value (esp_commit_value),
        .rd0_num          (src0_num),
        .rd1_num          (src1_num),
        .rd0_value        (op0_value),
        .rd1_value        (op1_value),
        .esp_value        (committed_esp)
    );

    seg_file u_seg_file (
        .clk             (clk),
        .rst_n           (rst_n),
        .wb_seg_en       (wb_seg_en),
        .wb_seg_number   (wb_seg_number),
        .wb_seg_data     (wb_seg_data),
        .write_cs_enable (write_cs_enable),
        .write_cs        (write_cs),
        .rd_seg          (seg_sel),
        .seg_value       (seg_value),
        .ss_value        (ss_value)
    );

    reg_scoreboard u_reg_scoreboard (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .accept        (accept),
        .uop           (d_uop),
        .src0_num      (src0_num),
        .src1_num      (src1_num),
        .wb_reg_en     (wb_reg_en),
        .wb_reg_number (wb_reg_number),
        .stall         (stall)
    );

    stack_tracker u_stack_tracker (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush            (flush),
        .accept           (accept),
        .stack_op         (d_uop.stack_op),
        .size             (d_uop.size),
        .ss_value         (ss_value),
        .wb_reg_en        (wb_reg_en),
        .wb_reg_number    (wb_reg_number),
        .wb_stack         (wb_stack),
        .wb_reg_data      (wb_reg_data),
        .committed_esp    (committed_esp),
        .wb_stack_en      (wb_stack_en),
        .wb_stack_op      (wb_stack_op),
        .wb_stack_size    (wb_stack_size),
        .stack_address    (stack_address),
        .esp_commit_value (esp_commit_value)
    );

    always_comb begin
        next_uop               = '0;
        next_uop.uop           = d_uop;
        next_uop.uop.op0_reg   = src0_num;
        next_uop.uop.op1_reg   = src1_num;
        next_uop.op0_value     = op0_value;
        next_uop.op1_value     = op1_value;
        next_uop.seg_value     = seg_value;
        next_uop.stack_address = stack_address;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (flush) begin
            r_valid <= 1'b0;
        end else if (accept) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    // Payload only moves on accept, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            r_uop <= next_uop;
        end
    end

endmodule

//--- testbench/reg_access_tb.sv
/*
 * Register access stage testbench
 * Plays decode and writeback, models registers, scoreboard and stack
 * pointer, and checks every output transfer in order
 */
`timescale 1ns/1ns

module reg_access_tb;
    import reg_access_pkg::*;

    // Full run takes a few hundred cycles, so this leaves a wide margin
    localparam int MAX_CYCLES = 4000;

    logic        clk = 1'b0;
    logic        r_ready = 1'b1;
    logic        rst_n;
    logic        flush;
    logic        write_cs_enable;
    logic        d_valid;
    logic        d_ready;
    logic        r_valid;
    logic        wb_reg_en;
    logic        wb_stack;
    logic        wb_seg_en;
    logic        wb_stack_en;
    logic [15:0] write_cs;
    logic [15:0] wb_seg_data;
    logic [2:0]  wb_reg_number;
    logic [31:0] wb_reg_data;
    reg_size_e   wb_reg_size;
    reg_size_e   wb_stack_size;
    seg_e        wb_seg_number;
    stack_op_e   wb_stack_op;
    dec_uop_t    d_uop;
    ra_uop_t     r_uop;

    // Reference state
    logic [31:0] regs [8];
    logic [31:0] nx_regs [8];
    logic [15:0] segs [6];
    logic [15:0] nx_segs [6];
    logic [1:0]  pend [8];
    logic [31:0] spec_esp;
    logic        m_rvalid;
    logic        last_accept;
    ra_uop_t     exp_q [$];

    int     cycles = 0;
    int     errors = 0;
    int     checks = 0;
    int     accepts = 0;
    int     dut_accepts = 0;
    int     transfers = 0;
    integer seed = 83;
    string  test_name = "reset";
    logic   ready_pat [256];
    logic [7:0] pat_idx = 8'd0;
    logic   bp_mode = 1'b0;

    reg_access_top DUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] merge_sized(input logic [31:0] old_v,
                                                input logic [31:0] data, input reg_size_e sz);
        logic [31:0] mask;
        mask = (sz == SZ_BYTE) ? 32'h0000_00ff :
               (sz == SZ_WORD) ? 32'h0000_ffff : 32'hffff_ffff;
        return (old_v & ~mask) | (data & mask);
    endfunction

    function automatic logic [31:0] step_of(input reg_size_e sz);
        return (sz == SZ_WORD) ? 32'd2 : 32'd4;
    endfunction

    // Expected output of a micro-op accepted this cycle
    // Reads see the writes of this cycle
    function automatic ra_uop_t expected_uop(input dec_uop_t u);
        ra_uop_t     e;
        logic [2:0]  s0;
        logic [2:0]  s1;
        logic [2:0]  sel;
        logic [31:0] base;
        s0 = (u.op0_kind == OPK_MODRM_RM) ? u.modrm[2:0] : u.op0_reg;
        s1 = (u.op1_kind == OPK_MODRM_RM) ? u.modrm[2:0] : u.op1_reg;
        sel = u.seg_override_valid ? u.seg_override : 3'd3;
        base = {12'd0, nx_segs[2], 4'd0};
        e = '0;
        e.uop = u;
        e.uop.op0_reg = s0;
        e.uop.op1_reg = s1;
        e.op0_value = nx_regs[s0];
        e.op1_value = nx_regs[s1];
        e.seg_value = (sel < 3'd6) ? nx_segs[sel] : 16'd0;
        if (u.stack_op == STK_PUSH) begin
            e.stack_address = base + spec_esp - step_of(u.size);
        end else if (u.stack_op == STK_POP) begin
            e.stack_address = base + spec_esp;
        end
        return e;
    endfunction

    // Compare transfers first, then advance the model by one edge
    always @(posedge clk) begin : model_step
        logic       m_stall;
        logic       m_ready;
        logic       acc;
        logic [2:0] src0;
        logic [2:0] src1;
        ra_uop_t    exp;
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end else if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] = '0;
                pend[i] = '0;
            end
            for (int i = 0; i < 6; i++) begin
                segs[i] = '0;
            end
            spec_esp = '0;
            m_rvalid = 1'b0;
            last_accept = 1'b0;
        end else begin
            if (r_valid !== m_rvalid) begin
                errors++;
                $display("ERR %s r_valid: expected %b actual %b", test_name, m_rvalid, r_valid);
            end
            if (r_valid && r_ready) begin
                transfers++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: output transfer with no accepted micro-op outstanding",
                             test_name);
                end else begin
                    exp = exp_q.pop_front();
                    checks++;
                    if (r_uop !== exp) begin
                        errors++;
                        $display("ERR %s: expected %h actual %h", test_name, exp, r_uop);
                    end
                end
            end
            src0 = (d_uop.op0_kind == OPK_MODRM_RM) ? d_uop.modrm[2:0] : d_uop.op0_reg;
            src1 = (d_uop.op1_kind == OPK_MODRM_RM) ? d_uop.modrm[2:0] : d_uop.op1_reg;
            m_stall = ((d_uop.op0_kind == OPK_REG || d_uop.op0_kind == OPK_MODRM_RM) &&
                       pend[src0] != '0) ||
                      ((d_uop.op1_kind == OPK_REG || d_uop.op1_kind == OPK_MODRM_RM) &&
                       pend[src1] != '0) ||
                      (d_uop.stack_op != STK_NONE && pend[4] != '0);
            m_ready = (!m_rvalid || r_ready) && !m_stall && !flush;
            checks++;
            if (d_ready !== m_ready) begin
                errors++;
                $display("ERR %s d_ready: expected %b actual %b", test_name, m_ready, d_ready);
            end
            if (d_valid && d_ready) begin
                dut_accepts++;
            end
            acc = d_valid && m_ready;
            nx_regs = regs;
            nx_segs = segs;
            if (wb_reg_en) begin
                nx_regs[wb_reg_number] = merge_sized(regs[wb_reg_number], wb_reg_data, wb_reg_size);
            end
            if (wb_stack_en) begin
                nx_regs[4] = (wb_stack_op == STK_PUSH) ? regs[4] - step_of(wb_stack_size) :
                             (wb_stack_op == STK_POP)  ? regs[4] + step_of(wb_stack_size) : regs[4];
            end
            if (wb_seg_en && wb_seg_number <= GS) begin
                nx_segs[wb_seg_number] = wb_seg_data;
            end
            if (write_cs_enable) begin
                nx_segs[1] = write_cs;
            end
            if (acc) begin
                exp_q.push_back(expected_uop(d_uop));
                accepts++;
            end
            for (int i = 0; i < 8; i++) begin
                if (flush) begin
                    pend[i] = '0;
                end else begin
                    if (acc && d_uop.dest_valid && d_uop.dest_reg == 3'(i)) begin
                        pend[i] = pend[i] + 2'd1;
                    end
                    if (wb_reg_en && wb_reg_number == 3'(i)) begin
                        pend[i] = pend[i] - 2'd1;
                    end
                end
            end
            if (flush) begin
                spec_esp = regs[4];
            end else if (wb_reg_en && wb_reg_number == 3'd4 && !wb_stack) begin
                spec_esp = wb_reg_data;
            end else if (acc && d_uop.stack_op == STK_PUSH) begin
                spec_esp = spec_esp - step_of(d_uop.size);
            end else if (acc && d_uop.stack_op == STK_POP) begin
                spec_esp = spec_esp + step_of(d_uop.size);
            end
            // A flushed output slot is dropped
            if (flush) begin
                m_rvalid = 1'b0;
                exp_q.delete();
            end else if (acc) begin
                m_rvalid = 1'b1;
            end else if (r_ready) begin
                m_rvalid = 1'b0;
            end
            regs = nx_regs;
            segs = nx_segs;
            last_accept = acc;
        end
    end

    // Address generation side
    // Random stalls while bp_mode is set
    always @(negedge clk) begin
        if (bp_mode) begin
            r_ready = ready_pat[pat_idx];
            pat_idx = pat_idx + 8'd1;
        end else begin
            r_ready = 1'b1;
        end
    end

    function automatic dec_uop_t random_uop();
        dec_uop_t    u;
        logic [31:0] r;
        u = '0;
        r = $random(seed);
        u.size = reg_size_e'(r[1:0] % 2'd3);
        u.op0_kind = opnd_kind_e'(r[4:2] % 3'd5);
        u.op1_kind = opnd_kind_e'(r[7:5] % 3'd5);
        u.op0_reg = r[10:8];
        u.op1_reg = r[13:11];
        u.modrm = r[21:14];
        u.seg_override = seg_e'(r[24:22]);
        u.seg_override_valid = r[25];
        u.alu_op = r[29:26];
        u.imm = $random(seed);
        u.disp = $random(seed);
        u.pc = $random(seed);
        r = $random(seed);
        u.opcode = r[15:0];
        u.dest_reg = r[18:16];
        return u;
    endfunction

    task automatic clear_strobes();
        wb_reg_en = 1'b0;
        wb_stack = 1'b0;
        wb_seg_en = 1'b0;
        wb_stack_en = 1'b0;
        write_cs_enable = 1'b0;
        flush = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            clear_strobes();
        end
    endtask

    task automatic wait_accept();
        do begin
            @(negedge clk);
            clear_strobes();
        end while (!last_accept);
        d_valid = 1'b0;
    endtask

    task automatic issue(input dec_uop_t u);
        idle(1);
        d_valid = 1'b1;
        d_uop = u;
        wait_accept();
    endtask

    // A writeback retires a destination that an accepted micro-op opened
    task automatic reg_write(input logic [2:0] num, input reg_size_e sz,
                             input logic [31:0] data, input logic stk);
        dec_uop_t u;
        if (pend[num] == '0) begin
            u = random_uop();
            u.op0_kind = OPK_NONE;
            u.op1_kind = OPK_NONE;
            u.dest_valid = 1'b1;
            u.dest_reg = num;
            issue(u);
        end
        idle(1);
        wb_reg_en = 1'b1;
        wb_reg_number = num;
        wb_reg_size = sz;
        wb_reg_data = data;
        wb_stack = stk;
    endtask

    task automatic seg_write(input seg_e num, input logic [15:0] data);
        idle(1);
        wb_seg_en = 1'b1;
        wb_seg_number = num;
        wb_seg_data = data;
    endtask

    task automatic stack_commit(input stack_op_e op, input reg_size_e sz);
        idle(1);
        wb_stack_en = 1'b1;
        wb_stack_op = op;
        wb_stack_size = sz;
    endtask

    // Holds a micro-op that must stall, then releases it by writeback or flush
    task automatic hold_then_release(input dec_uop_t u, input logic use_flush,
                                     input logic [2:0] num, input logic [31:0] data);
        int n;
        idle(1);
        d_valid = 1'b1;
        d_uop = u;
        n = dut_accepts;
        idle(5);
        if (dut_accepts != n) begin
            errors++;
            $display("%s: micro-op accepted while its source had a pending write", test_name);
        end
        if (use_flush) begin
            flush = 1'b1;
        end else begin
            wb_reg_en = 1'b1;
            wb_reg_number = num;
            wb_reg_size = SZ_DWORD;
            wb_reg_data = data;
        end
        wait_accept();
    endtask

    initial begin : stimulus
        dec_uop_t    u;
        logic [31:0] r;
        rst_n = 1'b0;
        d_valid = 1'b0;
        d_uop = '0;
        write_cs = '0;
        wb_reg_number = '0;
        wb_reg_size = SZ_DWORD;
        wb_reg_data = '0;
        wb_seg_number = ES;
        wb_seg_data = '0;
        wb_stack_op = STK_NONE;
        wb_stack_size = SZ_DWORD;
        clear_strobes();
        for (int i = 0; i < 256; i++) begin
            r = $random(seed);
            ready_pat[i] = r[0];
        end
        idle(10);
        rst_n = 1'b1;

        test_name = "passthrough";
        for (int i = 0; i < 8; i++) begin
            reg_write(3'(i), SZ_DWORD, $random(seed), 1'b0);
        end
        repeat (24) issue(random_uop());

        test_name = "sized_write";
        u = random_uop();
        u.op0_kind = OPK_REG;
        u.op0_reg = 3'd2;
        reg_write(3'd2, SZ_DWORD, 32'h1122_3344, 1'b0);
        issue(u);
        reg_write(3'd2, SZ_BYTE, 32'hFFFF_FFAA, 1'b0);
        issue(u);
        reg_write(3'd2, SZ_WORD, 32'h5555_BEEF, 1'b0);
        issue(u);

        test_name = "hazard";
        u = random_uop();
        u.dest_valid = 1'b1;
        u.dest_reg = 3'd3;
        u.op0_kind = OPK_IMM;
        u.op1_kind = OPK_NONE;
        issue(u);
        u = random_uop();
        u.op0_kind = OPK_REG;
        u.op0_reg = 3'd3;
        hold_then_release(u, 1'b0, 3'd3, 32'hCAFE_0003);
        u = random_uop();
        u.dest_valid = 1'b1;
        u.dest_reg = 3'd5;
        u.op0_kind = OPK_NONE;
        u.op1_kind = OPK_NONE;
        issue(u);
        u.dest_valid = 1'b0;
        u.op1_kind = OPK_MODRM_RM;
        u.modrm = 8'hC5;
        hold_then_release(u, 1'b1, 3'd0, 32'd0);

        test_name = "stack";
        seg_write(SS, 16'h1234);
        reg_write(ESP_NUM, SZ_DWORD, 32'h0000_1000, 1'b0);
        for (int i = 0; i < 6; i++) begin
            u = random_uop();
            u.stack_op = (i < 3) ? STK_PUSH : STK_POP;
            u.size = i[0] ? SZ_WORD : SZ_DWORD;
            issue(u);
        end
        stack_commit(STK_PUSH, SZ_DWORD);
        stack_commit(STK_PUSH, SZ_WORD);
        u = random_uop();
        u.op0_kind = OPK_REG;
        u.op0_reg = ESP_NUM;
        // ESP read in the same cycle as a stack commit
        stack_commit(STK_POP, SZ_WORD);
        d_valid = 1'b1;
        d_uop = u;
        wait_accept();
        idle(1);
        flush = 1'b1;
        u.stack_op = STK_PUSH;
        u.size = SZ_WORD;
        issue(u);

        test_name = "segments";
        seg_write(ES, 16'h0111);
        seg_write(DS, 16'h0333);
        seg_write(FS, 16'h0444);
        seg_write(GS, 16'h0555);
        // Direct CS write against a writeback to CS in one cycle
        seg_write(CS, 16'h1111);
        write_cs_enable = 1'b1;
        write_cs = 16'h2222;
        for (int s = 0; s < 9; s++) begin
            u = random_uop();
            u.seg_override = seg_e'(3'(s));
            u.seg_override_valid = (s < 8);
            issue(u);
        end
        seg_write(SS, 16'h0F00);
        u.stack_op = STK_POP;
        issue(u);

        test_name = "back_pressure";
        @(posedge clk);
        bp_mode = 1'b1;
        repeat (40) begin
            u = random_uop();
            u.stack_op = stack_op_e'(u.alu_op[1:0] % 2'd3);
            issue(u);
        end
        @(posedge clk);
        bp_mode = 1'b0;
        idle(6);

        if (exp_q.size() != 0 || accepts != transfers) begin
            errors++;
            $display("Accepted %0d micro-ops but delivered %0d", accepts, transfers);
        end
        $display("Summary: %0d checks, %0d transfers, %0d errors", checks, transfers, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/reg_access_pkg.sv
rtl/gpr_file.sv
rtl/seg_file.sv
rtl/reg_scoreboard.sv
rtl/stack_tracker.sv
rtl/reg_access_top.sv
testbench/reg_access_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the register access stage testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -j 0 --top-module reg_access_tb -f list.f -o reg_access_sim
./obj_dir/reg_access_sim > sim.log 2>&1
cat sim.log
if grep -q "STATUS: PASS" sim.log; then
    exit 0
fi
exit 1
